// File: Bender.yml
package:
  name: eeprom_if

sources:
  - include_dirs:
      - hw
    files:
      - hw/eeprom_pkg.sv
      - hw/i2c_byte_engine.sv
      - hw/eeprom_wr.sv
      - hw/eeprom_if_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/eeprom_model.sv
      - test/tb_eeprom_if.sv

// File: hw/eeprom_if_top.sv
`timescale 1ns/1ps

module eeprom_if_top import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic        ack,
    output logic [7:0]  rdata,
    output logic        err,
    output logic        SCL,
    inout  wire         SDA
);

    logic       cmd_req;
    logic       cmd_ack;
    i2c_cmd_e   cmd;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic       nack;
    logic       scl_o;
    logic       sda_low;
    logic       sda_in;

    eeprom_wr i_eeprom_wr (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .cmd_ack (cmd_ack),
        .rx_byte (rx_byte),
        .nack    (nack),
        .ack     (ack),
        .rdata   (rdata),
        .err     (err),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .tx_byte (tx_byte)
    );

    i2c_byte_engine i_i2c_byte_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .tx_byte (tx_byte),
        .sda_in  (sda_in),
        .cmd_ack (cmd_ack),
        .rx_byte (rx_byte),
        .nack    (nack),
        .scl_o   (scl_o),
        .sda_low (sda_low)
    );

    // open drain pad with the pullup on the board
    assign SDA    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = SDA;
    assign SCL    = scl_o;   // push-pull as nothing stretches the clock

endmodule

// File: hw/eeprom_pkg.sv
package eeprom_pkg;

    // commands from the sequencer to the bit engine
    typedef enum logic [2:0] {
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read_ack,
        cmd_read_nack
    } i2c_cmd_e;

    // transaction sequencer states
    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_write,
        st_addr_write,
        st_data_write,
        st_restart,
        st_ctrl_read,
        st_data_read,
        st_stop,
        st_done
    } wr_state_e;

    // bit engine phases of half an SCL period each
    typedef enum logic [3:0] {
        ph_idle,
        ph_start_a,
        ph_start_b,
        ph_bit_low,
        ph_bit_high,
        ph_ack_low,
        ph_ack_high,
        ph_stop_a,
        ph_stop_b
    } bit_state_e;

endpackage

// File: hw/eeprom_settings.svh
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// CLK cycles per half SCL period
`define EEPROM_SCL_HALF 4

// max control byte attempts while the device is busy programming
`define EEPROM_POLL_LIMIT 16

// device type code of the 24Cxx family
`define EEPROM_DEV_CODE 4'b1010

`endif

// File: hw/eeprom_wr.sv
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_wr import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic        cmd_ack,
    input  logic [7:0]  rx_byte,
    input  logic        nack,
    output logic        ack,
    output logic [7:0]  rdata,
    output logic        err,
    output logic        cmd_req,
    output i2c_cmd_e    cmd,
    output logic [7:0]  tx_byte
);

    localparam int poll_limit = `EEPROM_POLL_LIMIT;
    localparam int try_w = $clog2(poll_limit + 1);
    localparam logic [try_w-1:0] try_last = try_w'(poll_limit);

    wr_state_e        state;
    logic             is_read;
    logic [10:0]      addr_q;
    logic [7:0]       wdata_q;
    logic [try_w-1:0] tries;      // control byte attempts so far
    logic             retry;      // stop is followed by another start
    logic             fail;
    logic [7:0]       ctrl_byte;
    i2c_cmd_e         cmd_sel;
    logic [7:0]       tx_sel;
    logic             cmd_state;
    logic             link_free;
    logic             link_done;

    // device code, block select, direction
    assign ctrl_byte = {`EEPROM_DEV_CODE, addr_q[10:8], (state == st_ctrl_read)};

    assign link_free = !cmd_req && !cmd_ack;
    assign link_done = cmd_req && cmd_ack;

    always_comb begin
        cmd_state = 1'b1;
        cmd_sel   = cmd_start;
        tx_sel    = 8'h00;
        case (state)
            st_start, st_restart: begin
                cmd_sel = cmd_start;
            end
            st_ctrl_write, st_ctrl_read: begin
                cmd_sel = cmd_write;
                tx_sel  = ctrl_byte;
            end
            st_addr_write: begin
                cmd_sel = cmd_write;
                tx_sel  = addr_q[7:0];
            end
            st_data_write: begin
                cmd_sel = cmd_write;
                tx_sel  = wdata_q;
            end
            st_data_read: begin
                cmd_sel = cmd_read_nack;   // single byte needs no master ack
                tx_sel  = 8'hff;
            end
            st_stop: begin
                cmd_sel = cmd_stop;
            end
            default: begin
                cmd_state = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= st_idle;
            cmd_req <= 1'b0;
            ack     <= 1'b0;
            err     <= 1'b0;
            tries   <= '0;
            retry   <= 1'b0;
            fail    <= 1'b0;
        end else begin
            // one engine command per state
            if (cmd_state && link_free) begin
                cmd_req <= 1'b1;
                cmd     <= cmd_sel;
                tx_byte <= tx_sel;
            end
            if (link_done) begin
                cmd_req <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (wr || rd) begin
                        is_read <= rd;
                        addr_q  <= addr;
                        wdata_q <= wdata;
                        tries   <= '0;
                        retry   <= 1'b0;
                        fail    <= 1'b0;
                        state   <= st_start;
                    end
                end

                st_start: begin
                    if (link_done) begin
                        tries <= tries + 1'b1;
                        state <= st_ctrl_write;
                    end
                end

                st_ctrl_write: begin
                    if (link_done) begin
                        if (nack) begin
                            // device busy programming so poll again up to the limit
                            retry <= (tries != try_last);
                            fail  <= (tries == try_last);
                            state <= st_stop;
                        end else begin
                            state <= st_addr_write;
                        end
                    end
                end

                st_addr_write: begin
                    if (link_done) begin
                        if (nack) begin
                            fail  <= 1'b1;
                            state <= st_stop;
                        end else if (is_read) begin
                            state <= st_restart;
                        end else begin
                            state <= st_data_write;
                        end
                    end
                end

                st_data_write: begin
                    if (link_done) begin
                        fail  <= nack;
                        state <= st_stop;
                    end
                end

                st_restart: begin
                    if (link_done) begin
                        state <= st_ctrl_read;
                    end
                end

                st_ctrl_read: begin
                    if (link_done) begin
                        fail  <= nack;
                        state <= nack ? st_stop : st_data_read;
                    end
                end

                st_data_read: begin
                    if (link_done) begin
                        rdata <= rx_byte;
                        state <= st_stop;
                    end
                end

                st_stop: begin
                    if (link_done) begin
                        if (retry) begin
                            retry <= 1'b0;
                            state <= st_start;
                        end else begin
                            ack   <= 1'b1;
                            err   <= fail;
                            state <= st_done;
                        end
                    end
                end

                st_done: begin
                    if (!wr && !rd) begin   // held request keeps ack up
                        ack   <= 1'b0;
                        err   <= 1'b0;
                        state <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: hw/i2c_byte_engine.sv
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module i2c_byte_engine import eeprom_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_req,
    input  i2c_cmd_e   cmd,
    input  logic [7:0] tx_byte,
    input  logic       sda_in,
    output logic       cmd_ack,
    output logic [7:0] rx_byte,
    output logic       nack,
    output logic       scl_o,
    output logic       sda_low
);

    localparam int half = `EEPROM_SCL_HALF;
    localparam int cnt_w = (half > 1) ? $clog2(half) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half - 1);
    localparam logic [cnt_w-1:0] cnt_mid = cnt_w'(half / 2 - 1);

    bit_state_e       phase;
    logic [cnt_w-1:0] cnt;        // position inside the current half period
    logic [2:0]       bit_cnt;
    logic [7:0]       shreg;      // shared by transmit and receive
    i2c_cmd_e         cmd_q;
    logic             phase_end;
    logic             at_mid;

    assign phase_end = (cnt == cnt_last);
    assign at_mid    = (cnt == cnt_mid);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            phase   <= ph_idle;
            cnt     <= '0;
            bit_cnt <= '0;
            cmd_ack <= 1'b0;
            scl_o   <= 1'b1;      // bus idles with both lines high
            sda_low <= 1'b0;
        end else begin
            if (phase == ph_idle || phase_end) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            case (phase)
                ph_idle: begin
                    if (cmd_ack && !cmd_req) begin
                        cmd_ack <= 1'b0;
                    end else if (cmd_req && !cmd_ack) begin
                        cmd_q   <= cmd;
                        shreg   <= tx_byte;
                        bit_cnt <= 3'd7;
                        case (cmd)
                            cmd_start: begin
                                sda_low <= 1'b0;   // SCL may still be low on a restart
                                phase   <= ph_start_a;
                            end
                            cmd_stop: begin
                                scl_o <= 1'b0;
                                phase <= ph_stop_a;
                            end
                            default: begin
                                scl_o <= 1'b0;
                                phase <= ph_bit_low;
                            end
                        endcase
                    end
                end

                ph_start_a: begin
                    if (at_mid) begin
                        scl_o <= 1'b1;
                    end
                    if (phase_end) begin
                        sda_low <= 1'b1;           // SDA falls while SCL high
                        phase   <= ph_start_b;
                    end
                end

                ph_start_b: begin
                    if (at_mid) begin
                        scl_o <= 1'b0;
                    end
                    if (phase_end) begin
                        cmd_ack <= 1'b1;
                        phase   <= ph_idle;
                    end
                end

                ph_bit_low: begin
                    // data changes only in the middle of SCL low
                    if (at_mid) begin
                        sda_low <= (cmd_q == cmd_write) ? ~shreg[7] : 1'b0;
                    end
                    if (phase_end) begin
                        scl_o <= 1'b1;
                        phase <= ph_bit_high;
                    end
                end

                ph_bit_high: begin
                    if (at_mid) begin
                        shreg <= {shreg[6:0], sda_in};  // msb first
                    end
                    if (phase_end) begin
                        scl_o <= 1'b0;
                        if (bit_cnt == 3'd0) begin
                            phase <= ph_ack_low;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                            phase   <= ph_bit_low;
                        end
                    end
                end

                ph_ack_low: begin
                    if (at_mid) begin
                        sda_low <= (cmd_q == cmd_read_ack);  // master ack only on read_ack
                    end
                    if (phase_end) begin
                        scl_o <= 1'b1;
                        phase <= ph_ack_high;
                    end
                end

                ph_ack_high: begin
                    if (at_mid) begin
                        nack <= sda_in;            // released line means no ack
                    end
                    if (phase_end) begin
                        scl_o   <= 1'b0;
                        rx_byte <= shreg;
                        cmd_ack <= 1'b1;
                        phase   <= ph_idle;
                    end
                end

                ph_stop_a: begin
                    if (at_mid) begin
                        sda_low <= 1'b1;
                    end
                    if (phase_end) begin
                        scl_o <= 1'b1;
                        phase <= ph_stop_b;
                    end
                end

                ph_stop_b: begin
                    if (at_mid) begin
                        sda_low <= 1'b0;           // SDA rises while SCL high
                    end
                    if (phase_end) begin
                        cmd_ack <= 1'b1;
                        phase   <= ph_idle;
                    end
                end

                default: begin
                    phase <= ph_idle;
                end
            endcase
        end
    end

endmodule

// File: src.f
+incdir+hw
hw/eeprom_pkg.sv
hw/i2c_byte_engine.sv
hw/eeprom_wr.sv
hw/eeprom_if_top.sv
test/eeprom_model.sv
test/tb_eeprom_if.sv

// File: test/eeprom_cases.txt
# name op addr data mode busy rdata err, addr data rdata in hex
# op is w or r, mode is normal, busy or dead, busy = refusals after the write
# rdata is only checked on reads that end without err
wr_a        w 012 a5 normal 0  00 0
rd_a        r 012 00 normal 0  a5 0
wr_b        w 7ff 3c normal 0  00 0
rd_b        r 7ff 00 normal 0  3c 0
wr_c        w 0fe 01 normal 0  00 0
wr_d        w 0ff 80 normal 0  00 0
rd_c        r 0fe 00 normal 0  01 0
rd_d        r 0ff 00 normal 0  80 0
wr_blk0     w 055 11 normal 0  00 0
wr_blk3     w 355 33 normal 0  00 0
wr_blk6     w 655 66 normal 0  00 0
rd_blk6     r 655 00 normal 0  66 0
rd_blk0     r 055 00 normal 0  11 0
rd_blk3     r 355 00 normal 0  33 0
wr_poll     w 123 c3 busy   5  00 0
rd_poll     r 123 00 normal 0  c3 0
wr_poll_max w 4a0 0f busy   15 00 0
rd_poll_max r 4a0 00 normal 0  0f 0
wr_dead     w 200 99 dead   0  00 1
rd_dead     r 012 00 dead   0  00 1
wr_stuck    w 321 77 busy   16 00 0
rd_stuck    r 321 00 normal 0  00 1
rd_after    r 321 00 normal 0  77 0
rd_a_again  r 012 00 normal 0  a5 0

// File: test/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_model (
    input  logic       scl,
    inout  wire        sda,
    input  logic       dead,           // never acknowledges
    input  logic [7:0] busy_refusals,  // taken when a write is programmed
    output int         start_count
);

    typedef enum logic [2:0] {m_off, m_ctrl, m_addr, m_data, m_send, m_done} mode_e;

    logic [7:0]  mem [0:2047];
    mode_e       mode;
    logic [3:0]  bits;          // scl rises seen in the current byte
    logic [7:0]  shreg;
    logic [7:0]  out_byte;
    logic [10:0] cur_addr;
    logic [7:0]  wr_byte;
    logic        wr_pend;
    logic        master_nack;
    int          busy;
    logic        sda_pull;

    assign sda = sda_pull ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        end
        mode        = m_off;
        bits        = 0;
        cur_addr    = 0;
        wr_pend     = 0;
        master_nack = 1;
        busy        = 0;
        sda_pull    = 0;
        start_count = 0;
    end

    // start is sda falling while scl high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            start_count = start_count + 1;
            mode        = m_ctrl;
            bits        = 0;
            wr_pend     = 0;
            sda_pull    = 0;
        end
    end

    // stop is sda rising while scl high and programs a pending write
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            if (wr_pend) begin
                mem[cur_addr] = wr_byte;
                busy          = busy_refusals;
            end
            wr_pend  = 0;
            mode     = m_off;
            bits     = 0;
            sda_pull = 0;
        end
    end

    always @(posedge scl) begin
        if (mode != m_off) begin
            if (bits < 8) begin
                shreg = {shreg[6:0], sda};
            end else if (bits == 8) begin
                master_nack = sda;     // also sees our own ack
            end
            bits = bits + 1;
        end
    end

    always @(negedge scl) begin
        if (mode != m_off) begin
            if (bits == 8) begin
                sda_pull = 0;
                case (mode)
                    m_ctrl: begin
                        if (shreg[7:4] == `EEPROM_DEV_CODE && !dead && busy == 0) begin
                            cur_addr[10:8] = shreg[3:1];
                            sda_pull       = 1;
                            mode           = shreg[0] ? m_send : m_addr;
                        end else begin
                            if (shreg[7:4] == `EEPROM_DEV_CODE && busy > 0) begin
                                busy = busy - 1;   // still programming
                            end
                            mode = m_off;
                        end
                    end
                    m_addr: begin
                        cur_addr[7:0] = shreg;
                        sda_pull      = 1;
                        mode          = m_data;
                    end
                    m_data: begin
                        wr_byte  = shreg;
                        wr_pend  = 1;
                        sda_pull = 1;
                        mode     = m_done;
                    end
                    default: begin
                        sda_pull = 0;          // master ack slot or ignored byte
                    end
                endcase
            end else if (bits == 9) begin
                bits     = 0;
                sda_pull = 0;
                if (mode == m_send) begin
                    if (master_nack) begin
                        mode = m_off;
                    end else begin
                        out_byte = mem[cur_addr];
                        cur_addr = cur_addr + 1;
                        sda_pull = ~out_byte[7];
                    end
                end
            end else if (mode == m_send && bits > 0) begin
                sda_pull = ~out_byte[7 - bits];
            end
        end
    end

endmodule

// File: test/tb_eeprom_if.sv
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module tb_eeprom_if;

    localparam int case_cycles = (`EEPROM_POLL_LIMIT + 4) * 40 * `EEPROM_SCL_HALF;
    localparam int max_cases = 64;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        ack;
    logic [7:0]  rdata;
    logic        err;
    wire         scl;
    wire         sda;
    logic        model_dead;
    logic [7:0]  model_busy;
    int          start_count;

    string       c_name [max_cases];
    logic        c_read [max_cases];
    logic [10:0] c_addr [max_cases];
    logic [7:0]  c_data [max_cases];
    logic        c_dead [max_cases];
    logic [7:0]  c_busy [max_cases];
    logic [7:0]  c_rdata [max_cases];
    logic        c_err [max_cases];
    int          n_cases;
    int          passed;
    int          check_errors;
    logic        cases_ready;

    pullup (sda);

    eeprom_if_top i_eeprom_if_top (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .err   (err),
        .SCL   (scl),
        .SDA   (sda)
    );

    eeprom_model i_eeprom_model (
        .scl           (scl),
        .sda           (sda),
        .dead          (model_dead),
        .busy_refusals (model_busy),
        .start_count   (start_count)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic load_cases();
        int          fd;
        int          fields;
        string       line;
        string       name;
        string       op;
        string       mode;
        logic [10:0] a;
        logic [7:0]  d;
        int          busy;
        logic [7:0]  exp_d;
        int          exp_e;
        fd = $fopen("test/eeprom_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/eeprom_cases.txt");
            check_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %s %h %h %s %d %h %d",
                                 name, op, a, d, mode, busy, exp_d, exp_e);
                if (fields == 8 && n_cases < max_cases) begin   // comment lines fall out here
                    if (mode != "normal" && mode != "busy" && mode != "dead") begin
                        $display("case %s has an unknown model mode %s", name, mode);
                        check_errors++;
                    end
                    c_name[n_cases]  = name;
                    c_read[n_cases]  = (op == "r");
                    c_addr[n_cases]  = a;
                    c_data[n_cases]  = d;
                    c_dead[n_cases]  = (mode == "dead");
                    c_busy[n_cases]  = (mode == "busy") ? 8'(busy) : 8'd0;
                    c_rdata[n_cases] = exp_d;
                    c_err[n_cases]   = exp_e[0];
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_bus_idle(input string where);
        assert (scl === 1'b1 && sda === 1'b1 && ack === 1'b0 && err === 1'b0) else begin
            $display("bus not idle after %s: scl=%b sda=%b ack=%b err=%b",
                     where, scl, sda, ack, err);
            check_errors++;
        end
    endtask

    task automatic run_case(input int idx);
        int errs_before;
        int starts_at_ack;
        int hold;
        int gap;
        errs_before = check_errors;
        @(negedge CLK);
        model_dead = c_dead[idx];
        model_busy = c_busy[idx];
        addr       = c_addr[idx];
        wdata      = c_data[idx];
        wr         = !c_read[idx];
        rd         = c_read[idx];
        while (ack !== 1'b1) @(negedge CLK);
        starts_at_ack = start_count;
        assert (err === c_err[idx]) else begin
            $display("FAILED %s: err expected %0b, actual %0b", c_name[idx], c_err[idx], err);
            check_errors++;
        end
        if (c_read[idx] && !c_err[idx]) begin
            assert (rdata === c_rdata[idx]) else begin
                $display("FAILED %s: rdata expected %h, actual %h",
                         c_name[idx], c_rdata[idx], rdata);
                check_errors++;
            end
        end
        hold = $urandom_range(15, 0);   // request held past ack
        repeat (hold) begin
            @(negedge CLK);
            assert (ack === 1'b1) else begin
                $display("%s: ack fell while the request was still held", c_name[idx]);
                check_errors++;
            end
            assert (start_count == starts_at_ack) else begin
                $display("%s: a new transaction started during the held request", c_name[idx]);
                check_errors++;
            end
        end
        wr = 1'b0;
        rd = 1'b0;
        while (ack === 1'b1) @(negedge CLK);
        assert (start_count == starts_at_ack) else begin
            $display("%s: a start condition appeared after ack", c_name[idx]);
            check_errors++;
        end
        gap = $urandom_range(7, 0);
        check_bus_idle(c_name[idx]);
        repeat (gap) begin
            @(negedge CLK);
            check_bus_idle(c_name[idx]);
        end
        if (check_errors == errs_before) begin
            $display("%s passed", c_name[idx]);
            passed++;
        end else begin
            $display("%s failed", c_name[idx]);
        end
    endtask

    initial begin
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        model_dead   = 1'b0;
        model_busy   = '0;
        n_cases      = 0;
        passed       = 0;
        check_errors = 0;
        cases_ready  = 1'b0;
        void'($urandom(32'h9021_50d4));
        load_cases();
        cases_ready = 1'b1;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_bus_idle("reset");
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 n_cases, passed, n_cases - passed, check_errors);
        if (check_errors == 0 && n_cases > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog sized from the number of cases
    initial begin
        wait (cases_ready === 1'b1);
        repeat (n_cases * case_cycles + 20) @(posedge CLK);
        $display("timeout: the tests did not finish within %0d cycles",
                 n_cases * case_cycles + 20);
        $display("Test FAILED");
        $finish;
    end

endmodule
